//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_cpu
FILELIST = files.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list the targets"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- cpu_addr_unit.sv
`timescale 1ns/1ps

module cpu_addr_unit import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input ctrl_t ctrl,
	input data_t bus,
	input data_t jump_low,
	input data_t mem_rdata,
	output addr_t mem_addr
);

	addr_t pc;
	addr_t al;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			if (ctrl.pc_jmp)
				pc <= {mem_rdata, jump_low}; // High byte arrives with the strobe
			else if (ctrl.pc_inc)
				pc <= pc + 16'd1;
		end
	end

	// Address latch for direct load and store
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al <= '0;
		end else begin
			if (ctrl.al_load_l)
				al[7:0] <= bus;
			if (ctrl.al_load_h)
				al[15:8] <= bus;
		end
	end

	assign mem_addr = (ctrl.addr_sel == ADDR_AL) ? al : pc;

endmodule

//--- cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
	input alu_in_t alu_in,
	output alu_out_t alu_out
);

	logic cin;
	logic carry;
	logic aux;
	logic [8:0] wide;
	logic [4:0] nibble;

	always_comb begin
		cin = alu_in.carry && (alu_in.alu_op == ALU_ADC || alu_in.alu_op == ALU_SBB);
		carry = 1'b0;
		aux = 1'b0;
		wide = {1'b0, alu_in.operand};
		nibble = '0;
		case (alu_in.alu_op)
		ALU_ADD, ALU_ADC: begin
			wide = {1'b0, alu_in.acc} + {1'b0, alu_in.operand} + {8'd0, cin};
			nibble = {1'b0, alu_in.acc[3:0]} + {1'b0, alu_in.operand[3:0]} + {4'd0, cin};
			carry = wide[8];
			aux = nibble[4];
		end
		ALU_SUB, ALU_SBB, ALU_CMP: begin
			wide = {1'b0, alu_in.acc} - {1'b0, alu_in.operand} - {8'd0, cin};
			nibble = {1'b0, alu_in.acc[3:0]} - {1'b0, alu_in.operand[3:0]} - {4'd0, cin};
			carry = wide[8]; // Borrow
			aux = nibble[4];
		end
		ALU_ANA: begin
			wide = {1'b0, alu_in.acc & alu_in.operand};
			aux = alu_in.acc[3] | alu_in.operand[3];
		end
		ALU_XRA: wide = {1'b0, alu_in.acc ^ alu_in.operand};
		ALU_ORA: wide = {1'b0, alu_in.acc | alu_in.operand};
		default: ;
		endcase
	end

	always_comb begin
		alu_out.result = wide[7:0];
		alu_out.flags = '0;
		alu_out.flags[FLAG_C] = carry;
		alu_out.flags[FLAG_ONE] = 1'b1;
		alu_out.flags[FLAG_P] = ^wide[7:0];
		alu_out.flags[FLAG_AC] = aux;
		alu_out.flags[FLAG_Z] = wide[7:0] == 8'd0;
		alu_out.flags[FLAG_S] = wide[7];
	end

endmodule

//--- cpu_decoder.sv
`timescale 1ns/1ps

module cpu_decoder import cpu_pkg::*; (
	input data_t ir,
	output decode_t dec
);

	always_comb begin
		dec.dst = ir[5:3];
		dec.src = ir[2:0];
		dec.cond = ir[5:3];
		dec.alu_op = alu_op_e'({1'b0, ir[5:3]});
		casez (ir)
		8'h76: dec.op = OP_HLT; // Must win over the MOV group
		8'b01??????: begin
			if (ir[5:3] != 3'd6 && ir[2:0] != 3'd6)
				dec.op = OP_MOV;
			else
				dec.op = OP_NOP; // Memory operand not supported
		end
		8'b10??????: dec.op = (ir[2:0] != 3'd6) ? OP_ALU : OP_NOP;
		8'b11???110: dec.op = OP_ALUI;
		8'b00???110: dec.op = (ir[5:3] != 3'd6) ? OP_MVI : OP_NOP;
		8'hC3: dec.op = OP_JMP;
		8'b11???010: dec.op = OP_JCC;
		8'h3A: dec.op = OP_LDA;
		8'h32: dec.op = OP_STA;
		default: dec.op = OP_NOP;
		endcase
	end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

	// ************************************************************
	// Basic types and status register layout
	// ************************************************************

	typedef logic [7:0] data_t;
	typedef logic [15:0] addr_t;

	localparam int unsigned FLAG_C = 0;
	localparam int unsigned FLAG_ONE = 1; // Always reads one
	localparam int unsigned FLAG_P = 2;
	localparam int unsigned FLAG_AC = 4;
	localparam int unsigned FLAG_Z = 6;
	localparam int unsigned FLAG_S = 7;

	localparam data_t RESET_PSR = 8'h02;
	localparam data_t PSR_FIXED_ZERO = 8'h28; // Bits 3 and 5

	localparam logic ADDR_PC = 1'b0;
	localparam logic ADDR_AL = 1'b1;

	// ************************************************************
	// Encodings
	// ************************************************************

	typedef enum logic [3:0] {
		FETCH, DECODE, MOV, MVI, ALU0, ALU1,
		JMP0, JMP1, DIR0, DIR1, DIR2, HALT
	} state_e;

	typedef enum logic [3:0] {
		OP_NOP, OP_MOV, OP_MVI, OP_ALU, OP_ALUI,
		OP_JMP, OP_JCC, OP_LDA, OP_STA, OP_HLT
	} op_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_ADC = 4'd1,
		ALU_SUB = 4'd2,
		ALU_SBB = 4'd3,
		ALU_ANA = 4'd4,
		ALU_XRA = 4'd5,
		ALU_ORA = 4'd6,
		ALU_CMP = 4'd7,
		ALU_NOP = 4'd8
	} alu_op_e;

	typedef enum logic [3:0] {
		DB_B = 4'd0,
		DB_C = 4'd1,
		DB_D = 4'd2,
		DB_E = 4'd3,
		DB_H = 4'd4,
		DB_L = 4'd5,
		DB_MEM = 4'd6, // Sits on register code 6
		DB_A = 4'd7,
		DB_ALU = 4'd8, // Result as source, operand latch as destination
		DB_PSR = 4'd9,
		DB_ALL = 4'd10,
		DB_ALH = 4'd11,
		DB_NONE = 4'd15
	} db_sel_e;

	// ************************************************************
	// Bundles
	// ************************************************************

	typedef struct packed {
		db_sel_e db_src;
		db_sel_e db_dst;
		alu_op_e alu_op;
		data_t set_flags;
		logic pc_inc;
		logic pc_jmp;
		logic al_load_l;
		logic al_load_h;
		logic addr_sel;
	} ctrl_t;

	typedef struct packed {
		alu_op_e alu_op;
		data_t acc;
		data_t operand;
		logic carry;
	} alu_in_t;

	typedef struct packed {
		data_t result;
		data_t flags;
	} alu_out_t;

	typedef struct packed {
		op_e op;
		logic [2:0] dst;
		logic [2:0] src;
		alu_op_e alu_op;
		logic [2:0] cond;
	} decode_t;

endpackage

//--- cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input addr_t mem_addr,
	input data_t mem_wdata,
	input logic mem_done,
	input logic halted
);

	// ************************************************************
	// Memory interface rules
	// ************************************************************

	assert property (@(posedge clk) disable iff (!rst_n) !(mem_read && mem_write))
		else $error("read and write requested in the same cycle");

	// A waiting request keeps its kind, address and write data
	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read || mem_write) && !mem_done |=>
		$stable(mem_read) && $stable(mem_write) && $stable(mem_addr) &&
		(!mem_write || $stable(mem_wdata)))
		else $error("request changed while waiting for done");

	assert property (@(posedge clk) disable iff (!rst_n) halted |-> !mem_read && !mem_write)
		else $error("memory request while halted");

endmodule

bind cpu_top cpu_properties u_properties (.*);

//--- cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input ctrl_t ctrl,
	input data_t mem_rdata,
	input alu_out_t alu_out,
	output alu_in_t alu_in,
	output data_t bus,
	output data_t psr,
	output data_t jump_low
);

	data_t gpr [8]; // Indexed by register code, slot 6 is M and stays idle
	data_t operand;
	data_t psr_merged;

	always_comb begin
		case (ctrl.db_src)
		DB_B, DB_C, DB_D, DB_E, DB_H, DB_L, DB_A: bus = gpr[ctrl.db_src[2:0]];
		DB_MEM: bus = mem_rdata;
		DB_ALU: bus = alu_out.result;
		default: bus = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
			operand <= '0;
		end else begin
			case (ctrl.db_dst)
			DB_B, DB_C, DB_D, DB_E, DB_H, DB_L, DB_A: gpr[ctrl.db_dst[2:0]] <= bus;
			DB_ALU: operand <= bus;
			default: ;
			endcase
		end
	end

	assign psr_merged = (psr & ~ctrl.set_flags) | (alu_out.flags & ctrl.set_flags);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			psr <= RESET_PSR;
		end else begin
			if (ctrl.set_flags != '0)
				psr <= (psr_merged & ~PSR_FIXED_ZERO) | RESET_PSR;
		end
	end

	assign alu_in.alu_op = ctrl.alu_op;
	assign alu_in.acc = gpr[7];
	assign alu_in.operand = operand;
	assign alu_in.carry = psr[FLAG_C];
	assign jump_low = operand; // Jump target low byte was read first

endmodule

//--- cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input data_t mem_rdata,
	input logic mem_done,
	input data_t psr,
	output logic mem_read,
	output logic mem_write,
	output ctrl_t ctrl,
	output logic fetch,
	output logic halted
);

	data_t ir;
	state_e state;
	decode_t dec;
	logic done;
	logic cond_ok;
	logic addr_sel;
	logic inc;
	logic jmp;
	db_sel_e src;
	db_sel_e dst;
	alu_op_e aop;
	data_t mask;

	cpu_decoder u_decoder (
		.ir(ir),
		.dec(dec)
	);

	assign done = !(mem_read || mem_write) || mem_done; // Idle states finish at once
	assign fetch = state == FETCH;
	assign halted = state == HALT;

	always_comb begin
		case (dec.cond)
		3'd0: cond_ok = !psr[FLAG_Z];
		3'd1: cond_ok = psr[FLAG_Z];
		3'd2: cond_ok = !psr[FLAG_C];
		3'd3: cond_ok = psr[FLAG_C];
		3'd4: cond_ok = !psr[FLAG_P];
		3'd5: cond_ok = psr[FLAG_P];
		3'd6: cond_ok = !psr[FLAG_S];
		default: cond_ok = psr[FLAG_S];
		endcase
	end

	// ************************************************************
	// State register and instruction register
	// ************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
			ir <= '0;
		end else if (done) begin
			case (state)
			FETCH: begin
				ir <= mem_rdata;
				state <= DECODE;
			end
			DECODE: begin
				case (dec.op)
				OP_MOV: state <= MOV;
				OP_MVI: state <= MVI;
				OP_ALU, OP_ALUI: state <= ALU0;
				OP_JMP, OP_JCC: state <= JMP0;
				OP_LDA, OP_STA: state <= DIR0;
				OP_HLT: state <= HALT;
				default: state <= FETCH;
				endcase
			end
			ALU0: state <= ALU1;
			JMP0: state <= JMP1;
			DIR0: state <= DIR1;
			DIR1: state <= DIR2;
			HALT: state <= HALT; // Only reset leaves
			default: state <= FETCH;
			endcase
		end
	end

	// ************************************************************
	// Memory requests and datapath control
	// ************************************************************

	always_comb begin
		mem_read = 1'b0;
		mem_write = 1'b0;
		addr_sel = ADDR_PC;
		src = DB_NONE;
		dst = DB_NONE;
		aop = ALU_NOP;
		mask = '0;
		inc = 1'b0;
		jmp = 1'b0;
		case (state)
		FETCH: begin
			mem_read = 1'b1;
			inc = 1'b1;
		end
		MOV: begin
			src = db_sel_e'({1'b0, dec.src});
			dst = db_sel_e'({1'b0, dec.dst});
		end
		MVI: begin
			mem_read = 1'b1;
			src = DB_MEM;
			dst = db_sel_e'({1'b0, dec.dst});
			inc = 1'b1;
		end
		ALU0: begin
			dst = DB_ALU;
			if (dec.op == OP_ALUI) begin
				mem_read = 1'b1;
				src = DB_MEM;
				inc = 1'b1;
			end else
				src = db_sel_e'({1'b0, dec.src});
		end
		ALU1: begin
			src = DB_ALU;
			dst = (dec.alu_op == ALU_CMP) ? DB_NONE : DB_A; // CMP only sets flags
			aop = dec.alu_op;
			mask = 8'hFF;
		end
		JMP0: begin
			mem_read = 1'b1;
			src = DB_MEM;
			dst = DB_ALU; // Low byte parks in the operand latch
			inc = 1'b1;
		end
		JMP1: begin
			mem_read = 1'b1;
			jmp = dec.op == OP_JMP || cond_ok;
			inc = !jmp;
		end
		DIR0, DIR1: begin
			mem_read = 1'b1;
			src = DB_MEM;
			dst = (state == DIR0) ? DB_ALL : DB_ALH;
			inc = 1'b1;
		end
		DIR2: begin
			addr_sel = ADDR_AL;
			if (dec.op == OP_LDA) begin
				mem_read = 1'b1;
				src = DB_MEM;
				dst = DB_A;
			end else begin
				mem_write = 1'b1;
				src = DB_A;
			end
		end
		default: ;
		endcase
	end

	always_comb begin
		ctrl.db_src = src; // Left ungated so write data holds during waits
		ctrl.db_dst = done ? dst : DB_NONE;
		ctrl.alu_op = aop;
		ctrl.set_flags = done ? mask : '0;
		ctrl.pc_inc = done && inc;
		ctrl.pc_jmp = done && jmp;
		ctrl.al_load_l = done && dst == DB_ALL;
		ctrl.al_load_h = done && dst == DB_ALH;
		ctrl.addr_sel = addr_sel;
	end

endmodule

//--- cpu_stim.txt
# T name starts a test; L addr byte loads the program; X addr byte is an expected store
T mov
L 0000 06 L 0001 11 L 0002 0E L 0003 22 L 0004 78 L 0005 32 L 0006 00 L 0007 02
L 0008 79 L 0009 32 L 000A 01 L 000B 02 L 000C 76
X 0200 11 X 0201 22
T alu
L 0000 3E L 0001 F0 L 0002 06 L 0003 20 L 0004 80 L 0005 0E L 0006 01 L 0007 89
L 0008 32 L 0009 00 L 000A 02 L 000B 90 L 000C 99 L 000D 32 L 000E 01 L 000F 02
L 0010 A0 L 0011 A9 L 0012 16 L 0013 84 L 0014 B2 L 0015 32 L 0016 02 L 0017 02
L 0018 76
X 0200 12 X 0201 F0 X 0202 A5
T cmp
L 0000 3E L 0001 05 L 0002 C6 L 0003 03 L 0004 FE L 0005 08 L 0006 CA L 0007 0F
L 0008 00 L 0009 3E L 000A EE L 000B 32 L 000C 00 L 000D 02 L 000E 76 L 000F 32
L 0010 00 L 0011 02 L 0012 76
X 0200 08
T jumps
L 0000 3E L 0001 F0 L 0002 C6 L 0003 10
L 0004 C2 L 0005 0A L 0006 00 L 0007 32 L 0008 10 L 0009 02
L 000A CA L 000B 10 L 000C 00 L 000D 32 L 000E 11 L 000F 02
L 0010 D2 L 0011 16 L 0012 00 L 0013 32 L 0014 12 L 0015 02
L 0016 DA L 0017 1C L 0018 00 L 0019 32 L 001A 13 L 001B 02
L 001C E2 L 001D 22 L 001E 00 L 001F 32 L 0020 14 L 0021 02
L 0022 EA L 0023 28 L 0024 00 L 0025 32 L 0026 15 L 0027 02
L 0028 F2 L 0029 2E L 002A 00 L 002B 32 L 002C 16 L 002D 02
L 002E FA L 002F 34 L 0030 00 L 0031 32 L 0032 17 L 0033 02
L 0034 3E L 0035 00 L 0036 C6 L 0037 80
L 0038 C2 L 0039 3E L 003A 00 L 003B 32 L 003C 20 L 003D 02
L 003E CA L 003F 44 L 0040 00 L 0041 32 L 0042 21 L 0043 02
L 0044 D2 L 0045 4A L 0046 00 L 0047 32 L 0048 22 L 0049 02
L 004A DA L 004B 50 L 004C 00 L 004D 32 L 004E 23 L 004F 02
L 0050 E2 L 0051 56 L 0052 00 L 0053 32 L 0054 24 L 0055 02
L 0056 EA L 0057 5C L 0058 00 L 0059 32 L 005A 25 L 005B 02
L 005C F2 L 005D 62 L 005E 00 L 005F 32 L 0060 26 L 0061 02
L 0062 FA L 0063 68 L 0064 00 L 0065 32 L 0066 27 L 0067 02 L 0068 76
X 0210 00 X 0212 00 X 0215 00 X 0217 00 X 0221 80 X 0223 80 X 0224 80 X 0226 80
T lda
L 0000 3A L 0001 00 L 0002 03 L 0003 3C L 0004 07 L 0005 32 L 0006 01 L 0007 02
L 0008 76 L 0300 5A
X 0201 5A

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	output logic mem_read,
	output logic mem_write,
	output addr_t mem_addr,
	output data_t mem_wdata,
	input data_t mem_rdata,
	input logic mem_done,
	output logic fetch,
	output logic halted
);

	ctrl_t ctrl;
	data_t psr;
	data_t jump_low;
	alu_in_t alu_in;
	alu_out_t alu_out;

	cpu_sequencer u_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.mem_rdata(mem_rdata),
		.mem_done(mem_done),
		.psr(psr),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.ctrl(ctrl),
		.fetch(fetch),
		.halted(halted)
	);

	cpu_addr_unit u_addr_unit (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.bus(mem_wdata), // Internal bus doubles as write data
		.jump_low(jump_low),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr)
	);

	cpu_regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.mem_rdata(mem_rdata),
		.alu_out(alu_out),
		.alu_in(alu_in),
		.bus(mem_wdata),
		.psr(psr),
		.jump_low(jump_low)
	);

	cpu_alu u_alu (
		.alu_in(alu_in),
		.alu_out(alu_out)
	);

endmodule

//--- files.f
cpu_pkg.sv
cpu_decoder.sv
cpu_sequencer.sv
cpu_addr_unit.sv
cpu_regfile.sv
cpu_alu.sv
cpu_top.sv
cpu_properties.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

	typedef struct packed {
		addr_t addr;
		data_t data;
	} mem_rec_t;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	addr_t mem_addr;
	data_t mem_wdata;
	data_t mem_rdata;
	logic mem_done;
	logic fetch;
	logic halted;

	data_t mem [65536];
	mem_rec_t stores[$]; // Stores seen on the bus, in order
	mem_rec_t prog[$];
	mem_rec_t expected[$];
	string rec_kind[$];
	string rec_name[$];
	mem_rec_t rec_val[$];
	string cur_name;
	integer seed = 16135;
	logic busy;
	int unsigned wait_left;
	int error_count = 0;
	realtime timeout_ns = 0;

	cpu_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_done(mem_done),
		.fetch(fetch),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ************************************************************
	// Memory model with random wait states
	// ************************************************************

	always @(posedge clk) begin
		if (!rst_n) begin
			mem_done <= 1'b0;
			busy <= 1'b0;
		end else if (mem_done) begin
			mem_done <= 1'b0; // Access completes at this edge
			busy <= 1'b0;
			if (mem_write) begin
				mem[mem_addr] <= mem_wdata;
				stores.push_back('{addr: mem_addr, data: mem_wdata});
			end
		end else if (mem_read || mem_write) begin
			if (!busy) begin
				busy <= 1'b1;
				wait_left <= $unsigned($random(seed)) % 4;
			end else if (wait_left == 0) begin
				mem_done <= 1'b1;
				mem_rdata <= mem[mem_addr];
			end else
				wait_left <= wait_left - 1;
		end
	end

	task automatic stop_on_error(string msg);
		error_count++;
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_addr(string name, addr_t exp, addr_t act);
		if (exp !== act)
			stop_on_error($sformatf("mismatch %s: expected %04h, actual %04h", name, exp, act));
	endtask

	task automatic check_data(string name, data_t exp, data_t act);
		if (exp !== act)
			stop_on_error($sformatf("mismatch %s: expected %02h, actual %02h", name, exp, act));
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act)
			stop_on_error($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic read_stim();
		int fd;
		int n;
		string tok;
		string name;
		string line;
		addr_t a;
		data_t d;
		fd = $fopen("cpu_stim.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open the stim file cpu_stim.txt");
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
				break;
			if (tok == "#") begin
				n = $fgets(line, fd); // Rest of a comment line
			end else if (tok == "T") begin
				n = $fscanf(fd, "%s", name);
				rec_kind.push_back(tok);
				rec_name.push_back(name);
				rec_val.push_back('0);
			end else if (tok == "L" || tok == "X") begin
				n = $fscanf(fd, "%h %h", a, d);
				rec_kind.push_back(tok);
				rec_name.push_back("");
				rec_val.push_back('{addr: a, data: d});
			end else
				stop_on_error($sformatf("unknown record %s in the stim file", tok));
		end
		$fclose(fd);
	endtask

	task automatic run_test();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		for (int i = 0; i < 65536; i++)
			mem[i] = '0;
		foreach (prog[i])
			mem[prog[i].addr] = prog[i].data;
		stores.delete();
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit(cur_name, 1'b1, fetch); // First cycle fetches from address 0
		check_bit(cur_name, 1'b1, mem_read);
		check_addr(cur_name, 16'h0000, mem_addr);
		@(posedge clk);
		while (!halted)
			@(posedge clk);
		repeat (5) @(posedge clk); // Let the bus settle after HLT
		check_bit(cur_name, 1'b0, fetch);
		check_bit(cur_name, 1'b0, mem_read);
		if (stores.size() != expected.size())
			stop_on_error($sformatf("test %s stored %0d bytes where %0d were expected",
				cur_name, stores.size(), expected.size()));
		foreach (expected[i]) begin
			check_addr(cur_name, expected[i].addr, stores[i].addr);
			check_data(cur_name, expected[i].data, stores[i].data);
		end
		prog.delete();
		expected.delete();
	endtask

	initial begin
		int n_load;
		int n_test;
		rst_n = 1'b0;
		mem_done = 1'b0;
		mem_rdata = '0;
		n_load = 0;
		n_test = 0;
		read_stim();
		foreach (rec_kind[i]) begin
			if (rec_kind[i] == "L")
				n_load++;
			if (rec_kind[i] == "T")
				n_test++;
		end
		timeout_ns = n_load * 5 * 4 * 40 + n_test * 10 * 40;
		cur_name = "";
		foreach (rec_kind[i]) begin
			if (rec_kind[i] == "T") begin
				if (cur_name != "")
					run_test();
				cur_name = rec_name[i];
			end else if (rec_kind[i] == "L")
				prog.push_back(rec_val[i]);
			else
				expected.push_back(rec_val[i]);
		end
		if (cur_name != "")
			run_test();
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog
	initial begin
		wait (timeout_ns != 0);
		#(timeout_ns);
		stop_on_error("timeout: the core did not halt in time");
	end

endmodule
